// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  # RTL, in compile order
  - files:
      - hw/mips_pkg.sv
      - hw/mips_fetch.sv
      - hw/mips_decode.sv
      - hw/mips_execute.sv
      - hw/mips_regfile.sv
      - hw/mips_top.sv

  # Testbench
  - target: simulation
    files:
      - sim/mips_tb.sv

// ==== filelist.f ====
hw/mips_pkg.sv
hw/mips_fetch.sv
hw/mips_decode.sv
hw/mips_execute.sv
hw/mips_regfile.sv
hw/mips_top.sv
sim/mips_tb.sv

// ==== hw/mips_decode.sv ====
module mips_decode (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    input  logic                                i_step,
    input  mips_pkg::instr_u                    i_instr,
    input  logic [mips_pkg::DATA_W-1:0]         i_rs_data,
    input  logic [mips_pkg::DATA_W-1:0]         i_rt_data,

    output logic [mips_pkg::REG_ADDR_W-1:0]     o_rs_addr,
    output logic [mips_pkg::REG_ADDR_W-1:0]     o_rt_addr,
    output logic                                o_halt_seen,

    output logic [mips_pkg::ALU_OP_W-1:0]       o_alu_op,
    output logic                                o_b_imm,
    output logic                                o_reg_write,
    output logic                                o_halt,
    output logic [mips_pkg::DATA_W-1:0]         o_a,
    output logic [mips_pkg::DATA_W-1:0]         o_b,
    output logic [mips_pkg::DATA_W-1:0]         o_imm,
    output logic [mips_pkg::REG_ADDR_W-1:0]     o_dst,
    output logic [mips_pkg::REG_ADDR_W-1:0]     o_src_rs,
    output logic [mips_pkg::REG_ADDR_W-1:0]     o_src_rt
);

    localparam int EXT_W = mips_pkg::DATA_W - mips_pkg::IMM_W;

    logic [mips_pkg::ALU_OP_W-1:0]     alu_op_d;
    logic                              b_imm_d;
    logic                              valid_d;
    logic                              halt_d;
    logic                              sign_ext_d;
    logic [mips_pkg::REG_ADDR_W-1:0]   dst_d;
    logic [mips_pkg::DATA_W-1:0]       imm_d;
    logic                              reg_write_d;

    assign o_rs_addr = i_instr.r.rs;
    assign o_rt_addr = i_instr.r.rt;

    always_comb begin
        alu_op_d   = mips_pkg::ALU_ADD;
        b_imm_d    = 1'b0;
        valid_d    = 1'b0;
        halt_d     = 1'b0;
        sign_ext_d = 1'b0;
        dst_d      = i_instr.i.rt;
        case (i_instr.r.opcode)
            mips_pkg::OP_RTYPE: begin
                dst_d   = i_instr.r.rd;
                valid_d = 1'b1;
                case (i_instr.r.funct)
                    mips_pkg::FN_ADDU: alu_op_d = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op_d = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op_d = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op_d = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op_d = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  alu_op_d = mips_pkg::ALU_SLT;
                    default:           valid_d  = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                valid_d    = 1'b1;
                b_imm_d    = 1'b1;
                sign_ext_d = 1'b1;
            end
            mips_pkg::OP_ANDI: begin
                valid_d  = 1'b1;
                b_imm_d  = 1'b1;
                alu_op_d = mips_pkg::ALU_AND;
            end
            mips_pkg::OP_ORI: begin
                valid_d  = 1'b1;
                b_imm_d  = 1'b1;
                alu_op_d = mips_pkg::ALU_OR;
            end
            mips_pkg::OP_LUI: begin
                valid_d  = 1'b1;
                b_imm_d  = 1'b1;
                alu_op_d = mips_pkg::ALU_LUI;
            end
            mips_pkg::OP_HALT: halt_d = 1'b1;
            default: ;
        endcase
    end

    assign imm_d = sign_ext_d ? {{EXT_W{i_instr.i.imm[mips_pkg::IMM_W-1]}}, i_instr.i.imm}
                              : {{EXT_W{1'b0}}, i_instr.i.imm};

    // r0 is never a real destination
    assign reg_write_d = valid_d && (dst_d != '0);

    assign o_halt_seen = halt_d;

    // ID/EX control
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_alu_op    <= mips_pkg::ALU_ADD;
            o_b_imm     <= 1'b0;
            o_reg_write <= 1'b0;
            o_halt      <= 1'b0;
        end else if (i_step) begin
            o_alu_op    <= alu_op_d;
            o_b_imm     <= b_imm_d;
            o_reg_write <= reg_write_d;
            o_halt      <= halt_d;
        end
    end

    // ID/EX operands and register numbers
    always_ff @(posedge i_clk) begin
        if (i_step) begin
            o_a      <= i_rs_data;
            o_b      <= i_rt_data;
            o_imm    <= imm_d;
            o_dst    <= dst_d;
            o_src_rs <= o_rs_addr;
            o_src_rt <= o_rt_addr;
        end
    end

endmodule

// ==== hw/mips_execute.sv ====
module mips_execute (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    input  logic                                i_step,

    input  logic [mips_pkg::ALU_OP_W-1:0]       i_alu_op,
    input  logic                                i_b_imm,
    input  logic                                i_reg_write,
    input  logic                                i_halt,
    input  logic [mips_pkg::DATA_W-1:0]         i_a,
    input  logic [mips_pkg::DATA_W-1:0]         i_b,
    input  logic [mips_pkg::DATA_W-1:0]         i_imm,
    input  logic [mips_pkg::REG_ADDR_W-1:0]     i_dst,
    input  logic [mips_pkg::REG_ADDR_W-1:0]     i_src_rs,
    input  logic [mips_pkg::REG_ADDR_W-1:0]     i_src_rt,

    output logic                                o_wb_we,
    output logic [mips_pkg::REG_ADDR_W-1:0]     o_wb_addr,
    output logic [mips_pkg::DATA_W-1:0]         o_wb_data,
    output logic                                o_halt
);

    localparam int LOW_W = mips_pkg::DATA_W - mips_pkg::IMM_W;

    logic                              wb_we_q;
    logic [mips_pkg::REG_ADDR_W-1:0]   wb_addr_q;
    logic [mips_pkg::DATA_W-1:0]       wb_data_q;
    logic                              halt_q;
    logic [mips_pkg::DATA_W-1:0]       op_a;
    logic [mips_pkg::DATA_W-1:0]       op_b_reg;
    logic [mips_pkg::DATA_W-1:0]       op_b;
    logic [mips_pkg::DATA_W-1:0]       alu_res;

    // Forward from EX/WB, r0 never gets written so it never matches
    assign op_a     = (wb_we_q && (wb_addr_q == i_src_rs)) ? wb_data_q : i_a;
    assign op_b_reg = (wb_we_q && (wb_addr_q == i_src_rt)) ? wb_data_q : i_b;
    assign op_b     = i_b_imm ? i_imm : op_b_reg;

    always_comb begin
        case (i_alu_op)
            mips_pkg::ALU_ADD: alu_res = op_a + op_b;
            mips_pkg::ALU_SUB: alu_res = op_a - op_b;
            mips_pkg::ALU_AND: alu_res = op_a & op_b;
            mips_pkg::ALU_OR:  alu_res = op_a | op_b;
            mips_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            mips_pkg::ALU_SLT: alu_res = {{(mips_pkg::DATA_W-1){1'b0}},
                                          ($signed(op_a) < $signed(op_b))};
            mips_pkg::ALU_LUI: alu_res = {op_b[mips_pkg::IMM_W-1:0], {LOW_W{1'b0}}};
            default:           alu_res = '0;
        endcase
    end

    // EX/WB control, halt stays set until reset
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wb_we_q <= 1'b0;
            halt_q  <= 1'b0;
        end else if (i_step) begin
            wb_we_q <= i_reg_write;
            halt_q  <= halt_q | i_halt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_step) begin
            wb_addr_q <= i_dst;
            wb_data_q <= alu_res;
        end
    end

    // Commit only on a stepped edge so a paused core keeps its registers
    assign o_wb_we   = wb_we_q & i_step;
    assign o_wb_addr = wb_addr_q;
    assign o_wb_data = wb_data_q;
    assign o_halt    = halt_q;

endmodule

// ==== hw/mips_fetch.sv ====
module mips_fetch (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    input  logic                                i_step,
    input  logic                                i_halt_seen,

    input  logic                                i_load_we,
    input  logic [mips_pkg::IMEM_ADDR_W-1:0]    i_load_addr,
    input  logic [mips_pkg::DATA_W-1:0]         i_load_data,

    output logic [mips_pkg::DATA_W-1:0]         o_pc,
    output mips_pkg::instr_u                    o_instr
);

    logic [mips_pkg::DATA_W-1:0]      imem [mips_pkg::IMEM_DEPTH];
    logic [mips_pkg::DATA_W-1:0]      pc_q;
    logic [mips_pkg::IMEM_ADDR_W-1:0] word_idx;
    logic [mips_pkg::DATA_W-1:0]      fetched;
    logic                             halted_q;
    logic                             hold;
    mips_pkg::instr_u                 ifid_q;

    // Load port writes the program
    always_ff @(posedge i_clk) begin
        if (i_load_we) begin
            imem[i_load_addr] <= i_load_data;
        end
    end

    assign word_idx = pc_q[mips_pkg::IMEM_ADDR_W+1:2];
    assign fetched  = imem[word_idx];

    // Once HALT has been seen in ID the front end stays frozen
    assign hold = i_halt_seen | halted_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q     <= '0;
            halted_q <= 1'b0;
        end else if (i_step) begin
            if (i_halt_seen) begin
                halted_q <= 1'b1;
            end
            if (!hold) begin
                pc_q <= pc_q + mips_pkg::DATA_W'(4);
            end
        end
    end

    // IF/ID, all zeros decodes as a no-op
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ifid_q <= '0;
        end else if (i_step) begin
            if (hold) begin
                ifid_q <= '0;
            end else begin
                ifid_q <= fetched;
            end
        end
    end

    assign o_pc    = pc_q;
    assign o_instr = ifid_q;

endmodule

// ==== hw/mips_pkg.sv ====
package mips_pkg;

    // Datapath and memory sizes
    localparam int DATA_W      = 32;
    localparam int IMEM_DEPTH  = 256;
    localparam int IMEM_ADDR_W = 8;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int IMM_W       = 16;
    localparam int OPCODE_W    = 6;
    localparam int FUNCT_W     = 6;
    localparam int SHAMT_W     = 5;

    // Primary opcodes
    localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'h00;
    localparam logic [OPCODE_W-1:0] OP_ADDIU = 6'h09;
    localparam logic [OPCODE_W-1:0] OP_ANDI  = 6'h0c;
    localparam logic [OPCODE_W-1:0] OP_ORI   = 6'h0d;
    localparam logic [OPCODE_W-1:0] OP_LUI   = 6'h0f;
    localparam logic [OPCODE_W-1:0] OP_HALT  = 6'h3f;

    // R-type function codes
    localparam logic [FUNCT_W-1:0] FN_ADDU = 6'h21;
    localparam logic [FUNCT_W-1:0] FN_SUBU = 6'h23;
    localparam logic [FUNCT_W-1:0] FN_AND  = 6'h24;
    localparam logic [FUNCT_W-1:0] FN_OR   = 6'h25;
    localparam logic [FUNCT_W-1:0] FN_XOR  = 6'h26;
    localparam logic [FUNCT_W-1:0] FN_SLT  = 6'h2a;

    // ALU operations
    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd5;
    localparam logic [ALU_OP_W-1:0] ALU_LUI = 3'd6;

    // One instruction word, seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0]   opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [SHAMT_W-1:0]    shamt;
            logic [FUNCT_W-1:0]    funct;
        } r;
        struct packed {
            logic [OPCODE_W-1:0]   opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [IMM_W-1:0]      imm;
        } i;
    } instr_u;

endpackage

// ==== hw/mips_regfile.sv ====
module mips_regfile (
    input  logic                                i_clk,
    input  logic                                i_arst_n,

    input  logic                                i_we,
    input  logic [mips_pkg::REG_ADDR_W-1:0]     i_waddr,
    input  logic [mips_pkg::DATA_W-1:0]         i_wdata,

    input  logic [mips_pkg::REG_ADDR_W-1:0]     i_raddr_a,
    input  logic [mips_pkg::REG_ADDR_W-1:0]     i_raddr_b,
    input  logic [mips_pkg::REG_ADDR_W-1:0]     i_debug_addr,

    output logic [mips_pkg::DATA_W-1:0]         o_rdata_a,
    output logic [mips_pkg::DATA_W-1:0]         o_rdata_b,
    output logic [mips_pkg::DATA_W-1:0]         o_debug_data
);

    logic [mips_pkg::DATA_W-1:0] regs [mips_pkg::NUM_REGS];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int k = 0; k < mips_pkg::NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Same-cycle write is visible to decode
    assign o_rdata_a = (i_raddr_a == '0) ? '0
                     : (i_we && (i_raddr_a == i_waddr)) ? i_wdata : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0) ? '0
                     : (i_we && (i_raddr_b == i_waddr)) ? i_wdata : regs[i_raddr_b];

    assign o_debug_data = regs[i_debug_addr];

endmodule

// ==== hw/mips_top.sv ====
module mips_top (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    input  logic                                i_step,

    input  logic                                i_load_we,
    input  logic [mips_pkg::IMEM_ADDR_W-1:0]    i_load_addr,
    input  logic [mips_pkg::DATA_W-1:0]         i_load_data,

    input  logic [mips_pkg::REG_ADDR_W-1:0]     i_debug_addr,

    output logic [mips_pkg::DATA_W-1:0]         o_pc,
    output logic [mips_pkg::DATA_W-1:0]         o_debug_data,
    output logic                                o_halt
);

    // IF/ID
    mips_pkg::instr_u                   ifid_instr;
    logic                               halt_seen;

    // Register file read ports
    logic [mips_pkg::REG_ADDR_W-1:0]    rs_addr;
    logic [mips_pkg::REG_ADDR_W-1:0]    rt_addr;
    logic [mips_pkg::DATA_W-1:0]        rs_data;
    logic [mips_pkg::DATA_W-1:0]        rt_data;

    // ID/EX
    logic [mips_pkg::ALU_OP_W-1:0]      idex_alu_op;
    logic                               idex_b_imm;
    logic                               idex_reg_write;
    logic                               idex_halt;
    logic [mips_pkg::DATA_W-1:0]        idex_a;
    logic [mips_pkg::DATA_W-1:0]        idex_b;
    logic [mips_pkg::DATA_W-1:0]        idex_imm;
    logic [mips_pkg::REG_ADDR_W-1:0]    idex_dst;
    logic [mips_pkg::REG_ADDR_W-1:0]    idex_src_rs;
    logic [mips_pkg::REG_ADDR_W-1:0]    idex_src_rt;

    // Writeback
    logic                               wb_we;
    logic [mips_pkg::REG_ADDR_W-1:0]    wb_addr;
    logic [mips_pkg::DATA_W-1:0]        wb_data;

    mips_fetch u_fetch (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_step      (i_step),
        .i_halt_seen (halt_seen),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .o_pc        (o_pc),
        .o_instr     (ifid_instr)
    );

    mips_decode u_decode (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_step      (i_step),
        .i_instr     (ifid_instr),
        .i_rs_data   (rs_data),
        .i_rt_data   (rt_data),
        .o_rs_addr   (rs_addr),
        .o_rt_addr   (rt_addr),
        .o_halt_seen (halt_seen),
        .o_alu_op    (idex_alu_op),
        .o_b_imm     (idex_b_imm),
        .o_reg_write (idex_reg_write),
        .o_halt      (idex_halt),
        .o_a         (idex_a),
        .o_b         (idex_b),
        .o_imm       (idex_imm),
        .o_dst       (idex_dst),
        .o_src_rs    (idex_src_rs),
        .o_src_rt    (idex_src_rt)
    );

    mips_execute u_execute (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_step      (i_step),
        .i_alu_op    (idex_alu_op),
        .i_b_imm     (idex_b_imm),
        .i_reg_write (idex_reg_write),
        .i_halt      (idex_halt),
        .i_a         (idex_a),
        .i_b         (idex_b),
        .i_imm       (idex_imm),
        .i_dst       (idex_dst),
        .i_src_rs    (idex_src_rs),
        .i_src_rt    (idex_src_rt),
        .o_wb_we     (wb_we),
        .o_wb_addr   (wb_addr),
        .o_wb_data   (wb_data),
        .o_halt      (o_halt)
    );

    mips_regfile u_regfile (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_we         (wb_we),
        .i_waddr      (wb_addr),
        .i_wdata      (wb_data),
        .i_raddr_a    (rs_addr),
        .i_raddr_b    (rt_addr),
        .i_debug_addr (i_debug_addr),
        .o_rdata_a    (rs_data),
        .o_rdata_b    (rt_data),
        .o_debug_data (o_debug_data)
    );

endmodule

// ==== sim/mips_tb.sv ====
module mips_tb;

    localparam int PERIOD       = 20;
    localparam int MAX_ROWS     = 32;
    localparam int PAUSE_AT     = 6;
    localparam int HALT_TIMEOUT = 200;

    localparam logic [15:0] LFSR_SEED = 16'd78;

    // Codes the core does not implement
    localparam logic [5:0] NO_FN   = 6'h00;
    localparam logic [5:0] OP_ADDI = 6'h08;
    localparam logic [5:0] OP_LW   = 6'h23;
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_NOR  = 6'h27;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [5:0]  funct;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm_set;
    } prog_row_t;

    logic        i_clk;
    logic        i_arst_n;
    logic        i_step;
    logic        i_load_we;
    logic [7:0]  i_load_addr;
    logic [31:0] i_load_data;
    logic [4:0]  i_debug_addr;
    logic [31:0] o_pc;
    logic [31:0] o_debug_data;
    logic        o_halt;

    prog_row_t   prog [MAX_ROWS];
    logic [15:0] imms [MAX_ROWS];
    logic [31:0] exp_regs [32];
    int          n_rows;
    int          halt_idx;
    logic [15:0] lfsr_q;

    mips_top mips_top_i (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_step       (i_step),
        .i_load_we    (i_load_we),
        .i_load_addr  (i_load_addr),
        .i_load_data  (i_load_data),
        .i_debug_addr (i_debug_addr),
        .o_pc         (o_pc),
        .o_debug_data (o_debug_data),
        .o_halt       (o_halt)
    );

    always #(PERIOD / 2) i_clk = ~i_clk;

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic add_row(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] rs,
                           input logic [4:0] rt, input logic [4:0] rd, input logic [15:0] set);
        prog[n_rows] = '{op, fn, rs, rt, rd, set};
        n_rows++;
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_imm(output logic [15:0] imm);
        imm = '0;
        for (int b = 0; b < 16; b++) begin
            imm    = {imm[14:0], lfsr_q[15]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic mips_pkg::instr_u encode_row(input prog_row_t row, input logic [15:0] imm);
        mips_pkg::instr_u w;
        w = '0;
        if (row.opcode == mips_pkg::OP_RTYPE) begin
            w.r.opcode = row.opcode;
            w.r.rs     = row.rs;
            w.r.rt     = row.rt;
            w.r.rd     = row.rd;
            w.r.funct  = row.funct;
        end else begin
            w.i.opcode = row.opcode;
            w.i.rs     = row.rs;
            w.i.rt     = row.rt;
            w.i.imm    = imm;
        end
        return w;
    endfunction

    task automatic build_program();
        logic [15:0] imm;
        n_rows = 0;
        add_row(mips_pkg::OP_ADDIU, NO_FN,            5'd0,  5'd1,  5'd0,  16'h0000);
        add_row(mips_pkg::OP_ADDIU, NO_FN,            5'd1,  5'd2,  5'd0,  16'h0000);
        add_row(mips_pkg::OP_ORI,   NO_FN,            5'd1,  5'd3,  5'd0,  16'h8000);
        add_row(mips_pkg::OP_RTYPE, mips_pkg::FN_ADDU, 5'd2,  5'd3,  5'd4,  16'h0000);
        add_row(mips_pkg::OP_RTYPE, mips_pkg::FN_SUBU, 5'd4,  5'd1,  5'd5,  16'h0000);
        add_row(mips_pkg::OP_RTYPE, mips_pkg::FN_AND,  5'd5,  5'd4,  5'd6,  16'h0000);
        add_row(mips_pkg::OP_RTYPE, mips_pkg::FN_OR,   5'd6,  5'd5,  5'd7,  16'h0000);
        add_row(mips_pkg::OP_RTYPE, mips_pkg::FN_XOR,  5'd7,  5'd6,  5'd8,  16'h0000);
        add_row(mips_pkg::OP_RTYPE, mips_pkg::FN_SLT,  5'd8,  5'd7,  5'd9,  16'h0000);
        add_row(mips_pkg::OP_RTYPE, mips_pkg::FN_SLT,  5'd7,  5'd8,  5'd10, 16'h0000);
        add_row(mips_pkg::OP_LUI,   NO_FN,            5'd0,  5'd11, 5'd0,  16'h0000);
        add_row(mips_pkg::OP_ANDI,  NO_FN,            5'd8,  5'd12, 5'd0,  16'h8000);
        add_row(mips_pkg::OP_ADDIU, NO_FN,            5'd11, 5'd13, 5'd0,  16'h8000);
        add_row(mips_pkg::OP_RTYPE, mips_pkg::FN_SLT,  5'd13, 5'd0,  5'd14, 16'h0000);
        // Writes aimed at r0
        add_row(mips_pkg::OP_RTYPE, mips_pkg::FN_ADDU, 5'd1,  5'd2,  5'd0,  16'h0000);
        add_row(mips_pkg::OP_ADDIU, NO_FN,            5'd5,  5'd0,  5'd0,  16'h0000);
        add_row(mips_pkg::OP_RTYPE, mips_pkg::FN_ADDU, 5'd0,  5'd14, 5'd15, 16'h0000);
        // Unsupported codes
        add_row(OP_ADDI,            NO_FN,            5'd0,  5'd1,  5'd0,  16'h0000);
        add_row(OP_LW,              NO_FN,            5'd0,  5'd2,  5'd0,  16'h0000);
        add_row(mips_pkg::OP_RTYPE, FN_SLL,           5'd1,  5'd2,  5'd3,  16'h0000);
        add_row(mips_pkg::OP_RTYPE, FN_NOR,           5'd1,  5'd2,  5'd4,  16'h0000);
        add_row(mips_pkg::OP_RTYPE, mips_pkg::FN_SUBU, 5'd0,  5'd13, 5'd16, 16'h0000);
        add_row(mips_pkg::OP_RTYPE, mips_pkg::FN_XOR,  5'd1,  5'd16, 5'd1,  16'h0000);
        add_row(mips_pkg::OP_HALT,  NO_FN,            5'd0,  5'd0,  5'd0,  16'h0000);
        // Never reached
        add_row(mips_pkg::OP_ADDIU, NO_FN,            5'd0,  5'd17, 5'd0,  16'h0000);
        add_row(mips_pkg::OP_ORI,   NO_FN,            5'd0,  5'd1,  5'd0,  16'h0000);
        for (int n = 0; n < n_rows; n++) begin
            draw_imm(imm);
            imms[n] = imm | prog[n].imm_set;
        end
    endtask

    // Sequential ISA reference over the first rows of the table
    task automatic run_model(input int limit);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wr;
        for (int k = 0; k < 32; k++) begin
            exp_regs[k] = '0;
        end
        halt_idx = -1;
        for (int n = 0; n < n_rows && n < limit && halt_idx < 0; n++) begin
            a    = exp_regs[prog[n].rs];
            b    = exp_regs[prog[n].rt];
            sext = {{16{imms[n][15]}}, imms[n]};
            zext = {16'h0000, imms[n]};
            dst  = prog[n].rt;
            wr   = 1'b1;
            res  = '0;
            case (prog[n].opcode)
                mips_pkg::OP_RTYPE: begin
                    dst = prog[n].rd;
                    case (prog[n].funct)
                        mips_pkg::FN_ADDU: res = a + b;
                        mips_pkg::FN_SUBU: res = a - b;
                        mips_pkg::FN_AND:  res = a & b;
                        mips_pkg::FN_OR:   res = a | b;
                        mips_pkg::FN_XOR:  res = a ^ b;
                        mips_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:           wr  = 1'b0;
                    endcase
                end
                mips_pkg::OP_ADDIU: res = a + sext;
                mips_pkg::OP_ANDI:  res = a & zext;
                mips_pkg::OP_ORI:   res = a | zext;
                mips_pkg::OP_LUI:   res = {imms[n], 16'h0000};
                mips_pkg::OP_HALT: begin
                    wr       = 1'b0;
                    halt_idx = n;
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                exp_regs[dst] = res;
            end
        end
    endtask

    task automatic load_program();
        for (int n = 0; n < n_rows; n++) begin
            @(negedge i_clk);
            i_load_we   = 1'b1;
            i_load_addr = n[7:0];
            i_load_data = encode_row(prog[n], imms[n]);
        end
        @(negedge i_clk);
        i_load_we = 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
        @(negedge i_clk);
        i_debug_addr = addr;
        @(negedge i_clk);
        data = o_debug_data;
    endtask

    task automatic check_regs(input string tag);
        logic [31:0] data;
        for (int k = 0; k < 32; k++) begin
            read_reg(k[4:0], data);
            check_value($sformatf("o_debug_data r%0d (%s)", k, tag), data, exp_regs[k]);
        end
    endtask

    initial begin
        int          cycles;
        logic [31:0] halt_pc;
        i_clk        = 1'b0;
        i_arst_n     = 1'b0;
        i_step       = 1'b0;
        i_load_we    = 1'b0;
        i_load_addr  = '0;
        i_load_data  = '0;
        i_debug_addr = '0;
        lfsr_q       = LFSR_SEED;
        build_program();

        repeat (3) @(negedge i_clk);
        i_arst_n = 1'b1;

        run_model(0);
        check_value("o_pc", o_pc, 32'd0);
        check_value("o_halt", {31'd0, o_halt}, 32'd0);
        check_regs("reset");

        load_program();

        // Run part way and freeze the core
        @(negedge i_clk);
        i_step = 1'b1;
        repeat (PAUSE_AT) @(negedge i_clk);
        i_step = 1'b0;
        check_value("o_pc", o_pc, 32'(4 * PAUSE_AT));
        repeat (4) @(negedge i_clk);
        check_value("o_pc (paused)", o_pc, 32'(4 * PAUSE_AT));
        // Only rows fetched three or more steps before the pause have written back
        run_model(PAUSE_AT - 3);
        check_regs("paused");

        @(negedge i_clk);
        i_step = 1'b1;
        cycles = 0;
        while (!o_halt && cycles < HALT_TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        assert (o_halt) else begin
            $display("Timed out waiting for o_halt to rise");
            abort_run();
        end

        run_model(n_rows);

        // PC stops one word past HALT
        halt_pc = 32'(4 * (halt_idx + 1));
        check_value("o_pc (halted)", o_pc, halt_pc);
        repeat (5) begin
            @(negedge i_clk);
            check_value("o_pc (halted)", o_pc, halt_pc);
            check_value("o_halt", {31'd0, o_halt}, 32'd1);
        end
        i_step = 1'b0;
        check_regs("final");

        $display("Test completed successfully");
        $finish;
    end

endmodule
